//--- verilog/stream_src_pkg.sv
// shared widths, depths and config types of the memory-to-stream source
// strides are full byte offsets, lengths are counted in stream words
// total beats = len0 * len1, truncated to CNT_W bits
`default_nettype none

package stream_src_pkg;

  // widths
  localparam int DATA_W = 32;  // stream word
  localparam int MEM_W  = 64;  // one word wider, holds any misaligned word
  localparam int ADDR_W = 32;  // byte address
  localparam int CNT_W  = 16;  // lengths and beat counter

  // depths
  localparam int ADDR_FIFO_DEPTH = 2;
  localparam int OFFS_DEPTH      = 8;  // max grants without a response

  // register indices on the config port
  localparam logic [2:0] REG_BASE    = 3'd0;
  localparam logic [2:0] REG_STRIDE0 = 3'd1;
  localparam logic [2:0] REG_LEN0    = 3'd2;
  localparam logic [2:0] REG_STRIDE1 = 3'd3;
  localparam logic [2:0] REG_LEN1    = 3'd4;
  localparam logic [2:0] REG_START   = 3'd5;

  typedef struct packed {
    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] stride0;  // inner step
    logic [CNT_W-1:0]  len0;     // inner count
    logic [ADDR_W-1:0] stride1;  // outer step, from row start
    logic [CNT_W-1:0]  len1;     // outer count
  } src_cfg_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WORKING,
    ST_DRAIN
  } stream_state_e;

endpackage

`default_nettype wire

//--- verilog/stream_if.sv
// valid/ready stream with a generic payload
// once valid is up, valid and data hold until the beat transfers
`timescale 1ns/100ps
`default_nettype none

interface stream_if #(
  parameter type payload_t = logic
);

  logic     valid;
  logic     ready;
  payload_t data;

  // producer side
  modport source (
    output valid,
    output data,
    input  ready
  );

  // consumer side
  modport sink (
    input  valid,
    input  data,
    output ready
  );

endinterface

`default_nettype wire

//--- verilog/mem_if.sv
// read-only memory port, req/gnt request phase and r_valid response phase
// one r_valid per grant, in grant order, r_valid is a single-cycle pulse
`timescale 1ns/100ps
`default_nettype none

interface mem_if import stream_src_pkg::*; ();

  logic              req;
  logic [ADDR_W-1:0] add;      // word aligned byte address
  logic              gnt;
  logic              r_valid;
  logic [MEM_W-1:0]  r_data;   // bytes add .. add+7, little endian

  modport master (
    output req,
    output add,
    input  gnt,
    input  r_valid,
    input  r_data
  );

  modport slave (
    input  req,
    input  add,
    output gnt,
    output r_valid,
    output r_data
  );

endinterface

`default_nettype wire

//--- verilog/stream_fifo.sv
// synchronous valid/ready FIFO, flop based
// DEPTH must be 2 or more; push to pop takes one cycle
// pop data comes straight from the storage array
`timescale 1ns/100ps
`default_nettype none

module stream_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 2
) (
  input  wire      clk_i,
  input  wire      rst_ni,
  stream_if.sink   push_i,
  stream_if.source pop_o,
  output logic     empty_o
);

  payload_t                   mem_q [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(DEPTH)-1:0]   rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0] cnt_q;    // fill level
  logic                       do_push;
  logic                       do_pop;

  assign push_i.ready = (cnt_q != DEPTH);  // not full
  assign pop_o.valid  = (cnt_q != 0);
  assign pop_o.data   = mem_q[rd_ptr_q];
  assign empty_o      = (cnt_q == 0);

  assign do_push = push_i.valid & push_i.ready;
  assign do_pop  = pop_o.valid & pop_o.ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == DEPTH-1) ? '0 : wr_ptr_q + 1'b1;  // wrap
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == DEPTH-1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;  // both or neither
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_i.data;
    end
  end

endmodule

`default_nettype wire

//--- verilog/addr_gen.sv
// 2-D address walker: base + i*stride0 + j*stride1
// i runs the inner loop to len0, j the outer loop to len1
// len0 and len1 must be nonzero; cfg must hold still while a walk runs
// a start during a walk restarts it
`timescale 1ns/100ps
`default_nettype none

module addr_gen import stream_src_pkg::*; (
  input  wire           clk_i,
  input  wire           rst_ni,
  input  wire src_cfg_t cfg_i,
  input  wire           start_i,
  stream_if.source      addr_o,
  output logic          last_o
);

  logic              valid_q;
  logic [CNT_W-1:0]  i_q;       // inner index
  logic [CNT_W-1:0]  j_q;       // outer index
  logic [ADDR_W-1:0] addr_q;    // current address
  logic [ADDR_W-1:0] row_q;     // start of current row
  logic              inner_end;
  logic              last;
  logic              fire;

  assign inner_end = (i_q == cfg_i.len0 - 1'b1);
  assign last      = inner_end & (j_q == cfg_i.len1 - 1'b1);
  assign fire      = addr_o.valid & addr_o.ready;

  assign addr_o.valid = valid_q;
  assign addr_o.data  = addr_q;
  assign last_o       = valid_q & last;  // high with the final address

  // control counters
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      i_q     <= '0;
      j_q     <= '0;
    end else if (start_i) begin
      valid_q <= 1'b1;  // first address next cycle
      i_q     <= '0;
      j_q     <= '0;
    end else if (fire) begin
      if (last) begin
        valid_q <= 1'b0;  // walk finished
      end else if (inner_end) begin
        i_q <= '0;
        j_q <= j_q + 1'b1;
      end else begin
        i_q <= i_q + 1'b1;
      end
    end
  end

  // address datapath, step by adding a stride
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q <= cfg_i.base;
      row_q  <= cfg_i.base;
    end else if (fire && !last) begin
      if (inner_end) begin
        row_q  <= row_q + cfg_i.stride1;
        addr_q <= row_q + cfg_i.stride1;  // next row start
      end else begin
        addr_q <= addr_q + cfg_i.stride0;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/src_cfg_regs.sv
// config registers behind a four-phase req/ack port
// ack rises the cycle after req and falls the cycle after req drops
// START is write-only and fires only while the streamer is idle
// the host must not rewrite the pattern registers while busy
`timescale 1ns/100ps
`default_nettype none

module src_cfg_regs import stream_src_pkg::*; (
  input  wire        clk_i,
  input  wire        rst_ni,
  input  wire        cfg_req_i,
  input  wire  [2:0] cfg_idx_i,
  input  wire [31:0] cfg_wdata_i,
  input  wire        busy_i,
  input  wire        done_i,
  output logic       cfg_ack_o,
  output src_cfg_t   cfg_o,
  output logic       start_o,
  output logic       busy_o,
  output logic       done_o
);

  logic     ack_q;
  logic     start_q;
  logic     wr;        // new request this cycle
  src_cfg_t cfg_q;

  assign wr = cfg_req_i & ~ack_q;

  // four-phase ack and start pulse
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q   <= 1'b0;
      start_q <= 1'b0;
    end else begin
      if (wr) begin
        ack_q <= 1'b1;
      end else if (!cfg_req_i) begin
        ack_q <= 1'b0;  // req gone, release
      end
      // done cycle counts as busy, the core is still leaving its drain state
      start_q <= wr & (cfg_idx_i == REG_START) & ~busy_i & ~done_i;
    end
  end

  // register writes land with the rising ack
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q <= '0;
    end else if (wr) begin
      case (cfg_idx_i)
        REG_BASE:    cfg_q.base    <= cfg_wdata_i;
        REG_STRIDE0: cfg_q.stride0 <= cfg_wdata_i;
        REG_LEN0:    cfg_q.len0    <= cfg_wdata_i[CNT_W-1:0];
        REG_STRIDE1: cfg_q.stride1 <= cfg_wdata_i;
        REG_LEN1:    cfg_q.len1    <= cfg_wdata_i[CNT_W-1:0];
        default:     cfg_q         <= cfg_q;  // START and unused slots
      endcase
    end
  end

  assign cfg_ack_o = ack_q;
  assign cfg_o     = cfg_q;
  assign start_o   = start_q;
  assign busy_o    = busy_i;   // status straight from the core
  assign done_o    = done_i;

endmodule

`default_nettype wire

//--- verilog/core_source.sv
// streamer core: issues reads, tracks byte offsets, realigns beats
// each 64-bit beat yields bytes offs..offs+3 as one stream word
// requests are held back while the stream is not ready
// a held beat is overwritten if a second response comes before it is taken,
// so the memory must not answer twice while out_ready_i stays low
`timescale 1ns/100ps
`default_nettype none

module core_source import stream_src_pkg::*; (
  input  wire               clk_i,
  input  wire               rst_ni,
  input  wire src_cfg_t     cfg_i,
  input  wire               start_i,
  input  wire               gen_last_i,
  input  wire               addr_empty_i,
  stream_if.sink            addr_i,
  mem_if.master             mem_o,
  output logic              out_valid_o,
  output logic [DATA_W-1:0] out_data_o,
  input  wire               out_ready_i,
  output logic              busy_o,
  output logic              done_o
);

  stream_state_e    state_q, state_d;
  logic [CNT_W-1:0] beat_cnt_q;
  logic [CNT_W-1:0] tot_len;
  logic             hold_valid_q;
  logic [MEM_W-1:0] hold_data_q;
  logic [MEM_W-1:0] beat;          // live or held response
  logic             out_fire;
  logic             offs_empty;
  logic             done;

  stream_if #(.payload_t(logic [1:0])) offs_push ();
  stream_if #(.payload_t(logic [1:0])) offs_pop ();

  // byte offsets of granted, not yet delivered reads
  stream_fifo #(
    .payload_t (logic [1:0]),
    .DEPTH     (OFFS_DEPTH)
  ) i_offs_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (offs_push),
    .pop_o   (offs_pop),
    .empty_o (offs_empty)
  );

  assign tot_len = cfg_i.len0 * cfg_i.len1;

  // request side, gated by stream ready
  assign mem_o.req = (state_q != ST_IDLE) & addr_i.valid & out_ready_i & offs_push.ready;
  assign mem_o.add = {addr_i.data[ADDR_W-1:2], 2'b00};
  assign addr_i.ready = mem_o.req & mem_o.gnt;  // pop address on grant

  assign offs_push.valid = mem_o.req & mem_o.gnt;
  assign offs_push.data  = addr_i.data[1:0];

  // response side
  assign beat        = mem_o.r_valid ? mem_o.r_data : hold_data_q;
  assign out_valid_o = mem_o.r_valid | hold_valid_q;
  assign out_data_o  = beat[{offs_pop.data, 3'b000} +: DATA_W];  // realign
  assign out_fire    = out_valid_o & out_ready_i;
  assign offs_pop.ready = out_fire;

  // holding register for a beat the stream did not take
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_valid_q <= 1'b0;
    end else if (mem_o.r_valid) begin
      hold_valid_q <= ~out_ready_i;
    end else if (out_ready_i) begin
      hold_valid_q <= 1'b0;  // held beat accepted
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_o.r_valid) begin
      hold_data_q <= mem_o.r_data;
    end
  end

  // accepted beats of the current run
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_cnt_q <= '0;
    end else if (done) begin
      beat_cnt_q <= '0;
    end else if (out_fire) begin
      beat_cnt_q <= beat_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    done    = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (start_i) state_d = ST_WORKING;
      end
      ST_WORKING: begin
        if (gen_last_i) state_d = ST_DRAIN;  // final address on its way
      end
      ST_DRAIN: begin
        if (addr_empty_i && offs_empty && (beat_cnt_q == tot_len)) begin
          state_d = ST_IDLE;
          done    = 1'b1;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  assign busy_o = (state_q != ST_IDLE) & ~done;  // drops with done
  assign done_o = done;

endmodule

`default_nettype wire

//--- verilog/stream_src_top.sv
// memory-to-stream source: config regs, address walker, address FIFO, core
// memory sits outside on plain req/gnt/r_valid ports
// mem_addr_o is always word aligned, realignment happens inside
`timescale 1ns/100ps
`default_nettype none

module stream_src_top import stream_src_pkg::*; (
  input  wire               clk_i,
  input  wire               rst_ni,
  input  wire               cfg_req_i,
  input  wire         [2:0] cfg_idx_i,
  input  wire        [31:0] cfg_wdata_i,
  output logic              cfg_ack_o,
  output logic              busy_o,
  output logic              done_o,
  output logic              mem_req_o,
  output logic [ADDR_W-1:0] mem_addr_o,
  input  wire               mem_gnt_i,
  input  wire               mem_rvalid_i,
  input  wire   [MEM_W-1:0] mem_rdata_i,
  output logic              out_valid_o,
  output logic [DATA_W-1:0] out_data_o,
  input  wire               out_ready_i
);

  src_cfg_t cfg;
  logic     start;
  logic     gen_last;
  logic     addr_empty;
  logic     core_busy;
  logic     core_done;

  stream_if #(.payload_t(logic [ADDR_W-1:0])) addr_s ();  // walker to FIFO
  stream_if #(.payload_t(logic [ADDR_W-1:0])) addr_q ();  // FIFO to core
  mem_if mem ();

  // plain memory ports onto the interface
  assign mem_req_o   = mem.req;
  assign mem_addr_o  = mem.add;
  assign mem.gnt     = mem_gnt_i;
  assign mem.r_valid = mem_rvalid_i;
  assign mem.r_data  = mem_rdata_i;

  src_cfg_regs i_regs (
    .clk_i, .rst_ni, .cfg_req_i, .cfg_idx_i, .cfg_wdata_i,
    .busy_i    (core_busy),
    .done_i    (core_done),
    .cfg_ack_o,
    .cfg_o     (cfg),
    .start_o   (start),
    .busy_o,
    .done_o
  );

  addr_gen i_addr_gen (
    .clk_i, .rst_ni,
    .cfg_i   (cfg),
    .start_i (start),
    .addr_o  (addr_s),
    .last_o  (gen_last)
  );

  stream_fifo #(
    .payload_t (logic [ADDR_W-1:0]),
    .DEPTH     (ADDR_FIFO_DEPTH)
  ) i_addr_fifo (
    .clk_i, .rst_ni,
    .push_i  (addr_s),
    .pop_o   (addr_q),
    .empty_o (addr_empty)
  );

  core_source i_core (
    .clk_i, .rst_ni,
    .cfg_i        (cfg),
    .start_i      (start),
    .gen_last_i   (gen_last),
    .addr_empty_i (addr_empty),
    .addr_i       (addr_q),
    .mem_o        (mem),
    .out_valid_o, .out_data_o, .out_ready_i,
    .busy_o       (core_busy),
    .done_o       (core_done)
  );

endmodule

`default_nettype wire

//--- verif/stream_src_chk.sv
// handshake rules on the top-level ports, bound into stream_src_top
// the memory may not answer again while a beat waits on a low out_ready_i
// all rules are off while rst_ni is low
`timescale 1ns/100ps
`default_nettype none

module stream_src_chk import stream_src_pkg::*; (
  input wire              clk_i,
  input wire              rst_ni,
  input wire              cfg_req_i,
  input wire              cfg_ack_o,
  input wire              mem_rvalid_i,
  input wire              out_valid_o,
  input wire [DATA_W-1:0] out_data_o,
  input wire              out_ready_i,
  input wire              done_o
);

  int fail_cnt = 0;  // failed assertions so far

  // stalled beat keeps valid and data
  a_out_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_data_o)))
    else begin
      $error("stream beat dropped or changed before it was accepted");
      fail_cnt++;
    end

  // holding register has room for one beat only
  a_one_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (out_valid_o && !out_ready_i) |=> !mem_rvalid_i)
    else begin
      $error("memory answered while a stalled beat was still held");
      fail_cnt++;
    end

  // ack rises one cycle after req, host may already drop req then
  a_ack_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(cfg_ack_o) |-> $past(cfg_req_i))
    else begin
      $error("cfg_ack_o rose without a pending cfg_req_i");
      fail_cnt++;
    end

  a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |=> !done_o)
    else begin
      $error("done_o stayed high for more than one cycle");
      fail_cnt++;
    end

endmodule

bind stream_src_top stream_src_chk i_chk (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .cfg_req_i    (cfg_req_i),
  .cfg_ack_o    (cfg_ack_o),
  .mem_rvalid_i (mem_rvalid_i),
  .out_valid_o  (out_valid_o),
  .out_data_o   (out_data_o),
  .out_ready_i  (out_ready_i),
  .done_o       (done_o)
);

`default_nettype wire

//--- verif/stream_src_tb.sv
// testbench for stream_src_top with an in-order read memory model
// memory byte at address a is the xor of all four address bytes and 8'h5A
// inputs change on the falling edge, outputs are sampled 1 ns later
// memory never answers twice while out_ready_i stays low
`timescale 1ns/100ps
`default_nettype none

module stream_src_tb import stream_src_pkg::*; ();

  localparam int ACK_TIMEOUT  = 20;
  localparam int DONE_TIMEOUT = 4000;
  localparam int DRAIN_CYCLES = 10;  // quiet time to catch stray beats

  logic              clk_i;
  logic              rst_ni;
  logic              cfg_req_i;
  logic [2:0]        cfg_idx_i;
  logic [31:0]       cfg_wdata_i;
  logic              cfg_ack_o;
  logic              busy_o;
  logic              done_o;
  logic              mem_req_o;
  logic [ADDR_W-1:0] mem_addr_o;
  logic              mem_gnt_i;
  logic              mem_rvalid_i;
  logic [MEM_W-1:0]  mem_rdata_i;
  logic              out_valid_o;
  logic [DATA_W-1:0] out_data_o;
  logic              out_ready_i;

  logic [15:0]       lfsr_q;
  logic              rnd_mode;        // random gnt, latency and ready
  logic              held;            // mirror of the DUT holding register
  int                cyc;
  int                err_cnt;
  int                tmo_cnt;
  int                rx_cnt;          // accepted beats this run
  int                gnt_cnt;         // grants this run
  int                done_cnt;
  string             test_name;
  logic [ADDR_W-1:0] cur_base;
  logic [ADDR_W-1:0] cur_s0;
  logic [ADDR_W-1:0] cur_s1;
  int                cur_l0;
  int                cur_l1;
  logic [ADDR_W-1:0] pend_addr [$];   // granted word addresses
  int                pend_due [$];    // cycle each answer is due

  stream_src_top DUT (.*);

  always #2 clk_i = ~clk_i;  // 4 ns period

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output int v);
    v = 0;
    for (int b = 0; b < n; b++) begin
      lfsr_q = lfsr_step(lfsr_q);  // one step per bit
      v = (v << 1) | lfsr_q[0];
    end
  endtask

  function automatic logic [7:0] mem_byte(input logic [ADDR_W-1:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5A;
  endfunction

  // bytes w .. w+7, little endian
  function automatic logic [MEM_W-1:0] mem_beat(input logic [ADDR_W-1:0] w);
    logic [MEM_W-1:0] d;
    for (int b = 0; b < 8; b++) begin
      d[8*b +: 8] = mem_byte(w + b);
    end
    return d;
  endfunction

  // k-th pattern address, inner index k % l0, outer index k / l0
  function automatic logic [ADDR_W-1:0] pattern_addr(input logic [ADDR_W-1:0] base,
                                                     input logic [ADDR_W-1:0] s0,
                                                     input logic [ADDR_W-1:0] s1,
                                                     input int l0, input int k);
    return base + (k % l0) * s0 + (k / l0) * s1;
  endfunction

  // expected k-th word: bytes p .. p+3 of the k-th pattern address
  function automatic logic [DATA_W-1:0] ref_word(input logic [ADDR_W-1:0] base,
                                                 input logic [ADDR_W-1:0] s0,
                                                 input logic [ADDR_W-1:0] s1,
                                                 input int l0, input int k);
    logic [ADDR_W-1:0] p;
    logic [DATA_W-1:0] w;
    p = pattern_addr(base, s0, s1, l0, k);
    for (int b = 0; b < 4; b++) begin
      w[8*b +: 8] = mem_byte(p + b);
    end
    return w;
  endfunction

  // memory slave and stream sink
  always @(negedge clk_i) begin : mem_model
    int r;
    int lat;
    logic [ADDR_W-1:0] exp_addr;
    cyc++;
    out_ready_i = 1'b1;
    mem_gnt_i   = 1'b1;
    if (rnd_mode) begin
      draw_bits(2, r);
      out_ready_i = (r != 0);  // ready 3 of 4 cycles
      draw_bits(1, r);
      mem_gnt_i = r[0];
    end
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    if (pend_addr.size() > 0 && pend_due[0] <= cyc && !held) begin
      mem_rvalid_i = 1'b1;
      mem_rdata_i  = mem_beat(pend_addr.pop_front());
      void'(pend_due.pop_front());
    end
    held = mem_rvalid_i ? !out_ready_i : (held && !out_ready_i);
    #1;
    if (mem_req_o && mem_gnt_i) begin  // grant at the coming rising edge
      // word that holds the k-th pattern address
      exp_addr = pattern_addr(cur_base, cur_s0, cur_s1, cur_l0, gnt_cnt) & ~32'h3;
      assert (mem_addr_o === exp_addr) else begin
        err_cnt++;
        $display("ERROR %s grant %0d: expected %08h actual %08h",
                 test_name, gnt_cnt, exp_addr, mem_addr_o);
      end
      gnt_cnt++;
      lat = 1;
      if (rnd_mode) begin
        draw_bits(2, r);
        lat = r + 1;  // 1 to 4 cycles
      end
      pend_addr.push_back(mem_addr_o);
      pend_due.push_back(cyc + lat);
    end
  end

  // compare accepted beats with the reference
  always @(negedge clk_i) begin : compare
    logic [DATA_W-1:0] exp_word;
    #1;
    if (rst_ni && out_valid_o && out_ready_i) begin
      assert (rx_cnt < cur_l0 * cur_l1) else begin
        err_cnt++;
        $display("%s: beat %0d arrived after the pattern was complete", test_name, rx_cnt);
      end
      exp_word = ref_word(cur_base, cur_s0, cur_s1, cur_l0, rx_cnt);
      assert (out_data_o === exp_word) else begin
        err_cnt++;
        $display("ERROR %s beat %0d: expected %08h actual %08h",
                 test_name, rx_cnt, exp_word, out_data_o);
      end
      rx_cnt++;
    end
    if (rst_ni && done_o) begin
      done_cnt++;
    end
  end

  task automatic check_eq(input string what, input logic [31:0] exp_val,
                          input logic [31:0] act_val);
    assert (act_val === exp_val) else begin
      err_cnt++;
      $display("ERROR %s %s: expected %0h actual %0h", test_name, what, exp_val, act_val);
    end
  endtask

  task automatic wait_ack(input logic level, output int n);
    n = 0;
    while (cfg_ack_o !== level && n < ACK_TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (cfg_ack_o !== level) begin
      tmo_cnt++;
      $display("%s: timeout, cfg_ack_o never went to %0b", test_name, level);
    end
  endtask

  // one four-phase write, ack must follow req by one cycle each way
  task automatic cfg_write(input logic [2:0] idx, input logic [31:0] data);
    int n;
    @(negedge clk_i);
    cfg_req_i   = 1'b1;
    cfg_idx_i   = idx;
    cfg_wdata_i = data;
    wait_ack(1'b1, n);
    check_eq("ack rise delay", 1, n);
    cfg_req_i = 1'b0;
    wait_ack(1'b0, n);
    check_eq("ack fall delay", 1, n);
  endtask

  task automatic start_run(input string name, input logic [31:0] base,
                           input logic [31:0] s0, input int l0,
                           input logic [31:0] s1, input int l1);
    test_name = name;
    cur_base  = base;
    cur_s0    = s0;
    cur_l0    = l0;
    cur_s1    = s1;
    cur_l1    = l1;
    rx_cnt    = 0;
    gnt_cnt   = 0;
    done_cnt  = 0;
    cfg_write(REG_BASE, base);
    cfg_write(REG_STRIDE0, s0);
    cfg_write(REG_LEN0, l0);
    cfg_write(REG_STRIDE1, s1);
    cfg_write(REG_LEN1, l1);
    cfg_write(REG_START, 32'd1);
  endtask

  task automatic finish_run();
    int n;
    n = 0;
    while (done_cnt == 0 && n < DONE_TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (done_cnt == 0) begin
      tmo_cnt++;
      $display("%s: timeout, done_o never pulsed", test_name);
    end
    repeat (DRAIN_CYCLES) @(negedge clk_i);
    check_eq("beat count", cur_l0 * cur_l1, rx_cnt);
    check_eq("done pulses", 1, done_cnt);
    check_eq("busy after done", 0, busy_o);
  endtask

  initial begin
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    cfg_req_i    = 1'b0;
    cfg_idx_i    = '0;
    cfg_wdata_i  = '0;
    out_ready_i  = 1'b0;
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    lfsr_q       = 16'd98;  // seed
    rnd_mode     = 1'b0;
    held         = 1'b0;
    cyc          = 0;
    err_cnt      = 0;
    tmo_cnt      = 0;
    rx_cnt       = 0;
    gnt_cnt      = 0;
    done_cnt     = 0;
    cur_base     = '0;
    cur_s0       = '0;
    cur_s1       = '0;
    cur_l0       = 1;
    cur_l1       = 1;
    test_name    = "reset_state";
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    #1;
    check_eq("mem_req_o", 0, mem_req_o);
    check_eq("out_valid_o", 0, out_valid_o);
    check_eq("cfg_ack_o", 0, cfg_ack_o);
    check_eq("busy_o", 0, busy_o);
    check_eq("done_o", 0, done_o);

    start_run("aligned_1d", 32'h100, 32'd4, 8, 32'd0, 1);
    finish_run();

    start_run("misaligned_2d", 32'h203, 32'd5, 4, 32'h40, 3);
    finish_run();

    rnd_mode = 1'b1;  // idle here, nothing outstanding
    start_run("random_timing", 32'h1F1, 32'd3, 10, 32'h33, 3);
    finish_run();

    // second start while busy must be ignored
    start_run("cfg_handshake", 32'h402, 32'd4, 16, 32'h80, 2);
    check_eq("busy before second start", 1, busy_o);
    cfg_write(REG_START, 32'd1);
    finish_run();

    $display("closing: %0d value errors, %0d timeouts, %0d assertion failures",
             err_cnt, tmo_cnt, DUT.i_chk.fail_cnt);
    if (err_cnt == 0 && tmo_cnt == 0 && DUT.i_chk.fail_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- stream_src_top.f
verilog/stream_src_pkg.sv
verilog/stream_if.sv
verilog/mem_if.sv
verilog/stream_fifo.sv
verilog/addr_gen.sv
verilog/src_cfg_regs.sv
verilog/core_source.sv
verilog/stream_src_top.sv
verif/stream_src_chk.sv
verif/stream_src_tb.sv
